// File: Makefile
VERILATOR ?= verilator
TOP       ?= am_lock_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
hw/am_lock_pkg.sv
hw/am_lock_comparator.sv
hw/am_period_timer.sv
hw/am_lock_fsm.sv
hw/am_lock_cfg_regs.sv
hw/am_lock_top.sv
test/am_lock_props.sv
test/am_lock_tb.sv

// File: hw/am_lock_cfg_regs.sv
module am_lock_cfg_regs
(
	input  logic                    i_clock,
	input  logic                    i_reset,
	input  logic                    i_cfg_write,
	input  logic                    i_cfg_addr,
	input  logic [7:0]              i_cfg_wdata,
	input  am_lock_pkg::am_status_t i_status,

	output am_lock_pkg::am_cfg_t    o_cfg,
	output logic [7:0]              o_cfg_rdata
);

	localparam int CFG_W = $bits(am_lock_pkg::am_cfg_t);
	localparam am_lock_pkg::am_cfg_t CFG_RESET = '{
		bad_thresh:  3'd4,
		good_thresh: 3'd2,
		enable:      1'b1
	};

	am_lock_pkg::am_cfg_t ctrl_q;

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			ctrl_q <= CFG_RESET;
		else if (i_cfg_write && !i_cfg_addr) // Status address is read only.
			ctrl_q <= am_lock_pkg::am_cfg_t'(i_cfg_wdata[CFG_W-1:0]);
	end

	assign o_cfg = ctrl_q;

	always_comb
	begin
		if (i_cfg_addr)
			o_cfg_rdata = i_status;
		else
			o_cfg_rdata = {{(8 - CFG_W){1'b0}}, ctrl_q};
	end

endmodule

// File: hw/am_lock_comparator.sv
module am_lock_comparator
#(
	parameter int N_LANES = am_lock_pkg::N_LANES
)
(
	input  logic                           i_enable_mask,
	input  logic                           i_timer_done,
	input  logic [am_lock_pkg::AM_LEN-1:0] i_am_value,
	input  logic [N_LANES-1:0]             i_match_mask,

	output logic                           o_match,
	output logic [N_LANES-1:0]             o_match_vector
);

	localparam int LW = am_lock_pkg::LANE_W;

	logic [N_LANES-1:0] hits;
	logic               window;

	always_comb
	begin
		hits = '0;
		for (int i = 0; i < N_LANES; i++)
		begin
			if ((am_lock_pkg::am_table(LW'(i)) == i_am_value) && i_match_mask[i])
				hits[i] = 1'b1;
		end
	end

	// Open during search or on the expected marker slot.
	assign window         = i_timer_done | i_enable_mask;
	assign o_match        = (|hits) & window;
	assign o_match_vector = hits;

endmodule

// File: hw/am_lock_fsm.sv
module am_lock_fsm
#(
	parameter int N_LANES = am_lock_pkg::N_LANES
)
(
	input  logic                           i_clock,
	input  logic                           i_reset,
	input  logic                           i_block_valid,
	input  logic                           i_match,
	input  logic [N_LANES-1:0]             i_match_vector,
	input  logic                           i_timer_done,
	input  am_lock_pkg::am_cfg_t           i_cfg,

	output logic                           o_enable_mask,
	output logic [N_LANES-1:0]             o_match_mask,
	output logic                           o_restart,
	output am_lock_pkg::am_status_t        o_status,
	output logic                           o_locked,
	output logic [am_lock_pkg::LANE_W-1:0] o_lane
);

	localparam int LW = am_lock_pkg::LANE_W;
	localparam int CW = am_lock_pkg::CNT_W;
	localparam logic [N_LANES-1:0] ALL_LANES = '1;

	am_lock_pkg::lock_state_e state_q;
	am_lock_pkg::lock_state_e state_d;
	logic [CW-1:0]            good_q;
	logic [CW-1:0]            good_d;
	logic [CW-1:0]            bad_q;
	logic [CW-1:0]            bad_d;
	logic [N_LANES-1:0]       mask_q;
	logic [N_LANES-1:0]       mask_d;
	logic [LW-1:0]            lane_q;
	logic [LW-1:0]            lane_d;
	logic                     locked_q;
	logic [CW:0]              good_inc;
	logic [CW:0]              bad_inc;

	function automatic logic [LW-1:0] lane_index(input logic [N_LANES-1:0] onehot);
		logic [LW-1:0] idx;
		idx = '0;
		for (int i = 0; i < N_LANES; i++)
		begin
			if (onehot[i])
				idx = idx | LW'(i);
		end
		return idx;
	endfunction

	assign good_inc = {1'b0, good_q} + 1'b1;
	assign bad_inc  = {1'b0, bad_q} + 1'b1;

	always_comb
	begin
		state_d   = state_q;
		good_d    = good_q;
		bad_d     = bad_q;
		mask_d    = mask_q;
		lane_d    = lane_q;
		o_restart = 1'b0;
		if (i_block_valid)
		begin
			if (!i_cfg.enable)
			begin
				state_d = am_lock_pkg::ST_IDLE;
				good_d  = '0;
				bad_d   = '0;
				mask_d  = ALL_LANES;
				lane_d  = '0;
			end
			else
			begin
				unique case (state_q)
					am_lock_pkg::ST_IDLE:
						state_d = am_lock_pkg::ST_FIND;
					am_lock_pkg::ST_FIND:
					begin
						if (i_match)
						begin
							mask_d    = i_match_vector; // Lock search to this lane.
							lane_d    = lane_index(i_match_vector);
							good_d    = CW'(1);
							bad_d     = '0;
							o_restart = 1'b1;
							if (i_cfg.good_thresh <= CW'(1))
								state_d = am_lock_pkg::ST_LOCKED;
							else
								state_d = am_lock_pkg::ST_CONFIRM;
						end
					end
					am_lock_pkg::ST_CONFIRM:
					begin
						if (i_match)
						begin
							good_d = good_inc[CW-1:0];
							if (good_inc >= {1'b0, i_cfg.good_thresh})
								state_d = am_lock_pkg::ST_LOCKED;
						end
						else if (i_timer_done)
						begin
							state_d = am_lock_pkg::ST_FIND; // Missed marker.
							good_d  = '0;
							mask_d  = ALL_LANES;
							lane_d  = '0;
						end
					end
					am_lock_pkg::ST_LOCKED:
					begin
						if (i_match)
						begin
							bad_d = '0;
						end
						else if (i_timer_done)
						begin
							bad_d = bad_inc[CW-1:0];
							if (bad_inc >= {1'b0, i_cfg.bad_thresh})
							begin
								state_d = am_lock_pkg::ST_FIND;
								good_d  = '0;
								bad_d   = '0;
								mask_d  = ALL_LANES;
								lane_d  = '0;
							end
						end
					end
				endcase
			end
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			state_q  <= am_lock_pkg::ST_IDLE;
			good_q   <= '0;
			bad_q    <= '0;
			mask_q   <= ALL_LANES;
			lane_q   <= '0;
			locked_q <= 1'b0;
		end
		else
		begin
			state_q  <= state_d;
			good_q   <= good_d;
			bad_q    <= bad_d;
			mask_q   <= mask_d;
			lane_q   <= lane_d;
			locked_q <= (state_d == am_lock_pkg::ST_LOCKED);
		end
	end

	// Mask is all ones outside confirm and locked.
	assign o_enable_mask = (state_q == am_lock_pkg::ST_FIND);
	assign o_match_mask  = mask_q;
	assign o_locked      = locked_q;
	assign o_lane        = lane_q;
	assign o_status      = '{locked: locked_q, lane: lane_q, state: state_q};

endmodule

// File: hw/am_lock_pkg.sv
package am_lock_pkg;

	localparam int AM_LEN  = 48; // Marker width.
	localparam int N_LANES = 20;
	localparam int LANE_W  = 5;
	localparam int CNT_W   = 3; // Thresholds and counters.

	// Fixed alignment marker per virtual lane.
	function automatic logic [AM_LEN-1:0] am_table(input logic [LANE_W-1:0] lane);
		logic [AM_LEN-1:0] marker;
		case (lane)
			5'd0:    marker = 48'hC168213E97DE;
			5'd1:    marker = 48'h9D718E628E71;
			5'd2:    marker = 48'h594BE8A6B417;
			5'd3:    marker = 48'h4D957BB26A84;
			5'd4:    marker = 48'hF507090AF8F6;
			5'd5:    marker = 48'hDD14C222EB3D;
			5'd6:    marker = 48'h9A4A2665B5D9;
			5'd7:    marker = 48'h7B456684BA99;
			5'd8:    marker = 48'hA024765FDB89;
			5'd9:    marker = 48'h68C9FB973604;
			5'd10:   marker = 48'hFD6C99029366;
			5'd11:   marker = 48'hB99155466EAA;
			5'd12:   marker = 48'h5CB9B2A3464D;
			5'd13:   marker = 48'h1AF8BDE50742;
			5'd14:   marker = 48'h83C7CA7C3835;
			5'd15:   marker = 48'h3536CDCAC932;
			5'd16:   marker = 48'hC4314C3BCEB3;
			5'd17:   marker = 48'hADD6B7522948;
			5'd18:   marker = 48'h5F662AA099D5;
			5'd19:   marker = 48'hC0F0E53F0F1A;
			default: marker = '0;
		endcase
		return marker;
	endfunction

	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_FIND,
		ST_CONFIRM,
		ST_LOCKED
	} lock_state_e;

	// Control register layout, enable in bit 0.
	typedef struct packed
	{
		logic [CNT_W-1:0] bad_thresh;
		logic [CNT_W-1:0] good_thresh;
		logic             enable;
	} am_cfg_t;

	typedef struct packed
	{
		logic              locked;
		logic [LANE_W-1:0] lane;
		lock_state_e       state;
	} am_status_t;

endpackage

// File: hw/am_lock_top.sv
module am_lock_top
#(
	parameter int AM_PERIOD = 16384
)
(
	input  logic                           i_clock,
	input  logic                           i_reset,
	input  logic                           i_block_valid,
	input  logic [am_lock_pkg::AM_LEN-1:0] i_am_value,
	input  logic                           i_cfg_write,
	input  logic                           i_cfg_addr,
	input  logic [7:0]                     i_cfg_wdata,

	output logic [7:0]                     o_cfg_rdata,
	output logic                           o_locked,
	output logic [am_lock_pkg::LANE_W-1:0] o_lane
);

	localparam int N_LANES = am_lock_pkg::N_LANES;

	logic                    enable_mask;
	logic                    timer_done;
	logic                    match;
	logic [N_LANES-1:0]      match_mask;
	logic [N_LANES-1:0]      match_vector;
	logic                    restart;
	am_lock_pkg::am_cfg_t    cfg;
	am_lock_pkg::am_status_t status;

	am_lock_comparator #(.N_LANES(N_LANES)) u_comparator
	(
		.i_enable_mask  (enable_mask),
		.i_timer_done   (timer_done),
		.i_am_value     (i_am_value),
		.i_match_mask   (match_mask),
		.o_match        (match),
		.o_match_vector (match_vector)
	);

	am_period_timer #(.AM_PERIOD(AM_PERIOD)) u_timer
	(
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_block_valid (i_block_valid),
		.i_restart     (restart),
		.o_timer_done  (timer_done)
	);

	am_lock_fsm #(.N_LANES(N_LANES)) u_fsm
	(
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_block_valid  (i_block_valid),
		.i_match        (match),
		.i_match_vector (match_vector),
		.i_timer_done   (timer_done),
		.i_cfg          (cfg),
		.o_enable_mask  (enable_mask),
		.o_match_mask   (match_mask),
		.o_restart      (restart),
		.o_status       (status),
		.o_locked       (o_locked),
		.o_lane         (o_lane)
	);

	am_lock_cfg_regs u_regs
	(
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_cfg_write (i_cfg_write),
		.i_cfg_addr  (i_cfg_addr),
		.i_cfg_wdata (i_cfg_wdata),
		.i_status    (status),
		.o_cfg       (cfg),
		.o_cfg_rdata (o_cfg_rdata)
	);

endmodule

// File: hw/am_period_timer.sv
module am_period_timer
#(
	parameter int AM_PERIOD = 16384
)
(
	input  logic i_clock,
	input  logic i_reset,
	input  logic i_block_valid,
	input  logic i_restart,

	output logic o_timer_done
);

	localparam int TW = (AM_PERIOD > 1) ? $clog2(AM_PERIOD) : 1;
	localparam logic [TW-1:0] TERM = TW'(AM_PERIOD - 1);

	logic [TW-1:0] count_q; // Valid blocks since restart.

	assign o_timer_done = i_block_valid && (count_q == TERM);

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			count_q <= '0;
		end
		else if (i_block_valid)
		begin
			// Restart block and terminal block both begin a new period.
			if (i_restart || o_timer_done)
				count_q <= '0;
			else
				count_q <= count_q + 1'b1;
		end
	end

endmodule

// File: test/am_lock_props.sv
module am_lock_props
#(
	parameter int N_LANES = am_lock_pkg::N_LANES
)
(
	input logic                     i_clock,
	input logic                     i_reset,
	input am_lock_pkg::lock_state_e i_state,
	input logic                     i_match,
	input logic                     i_timer_done,
	input logic [N_LANES-1:0]       i_match_mask,
	input logic                     i_restart
);
	timeunit 1ns;
	timeprecision 100ps;

	// Tracked lane is judged only in its marker slot.
	match_only_on_slot: assert property (@(posedge i_clock) disable iff (i_reset)
		(((i_state == am_lock_pkg::ST_CONFIRM) || (i_state == am_lock_pkg::ST_LOCKED))
		&& i_match) |-> i_timer_done)
		else $error("match outside the marker slot in ST_CONFIRM or ST_LOCKED");

	// One lane tracked once a marker was found.
	mask_onehot: assert property (@(posedge i_clock) disable iff (i_reset)
		((i_state == am_lock_pkg::ST_CONFIRM) || (i_state == am_lock_pkg::ST_LOCKED))
		|-> $onehot(i_match_mask))
		else $error("match mask is not one-hot in ST_CONFIRM or ST_LOCKED");

	restart_mask_open: assert property (@(posedge i_clock) disable iff (i_reset)
		i_restart |-> (&i_match_mask))
		else $error("timer restart pulsed while the lane mask was narrowed");

endmodule

bind am_lock_fsm am_lock_props #(.N_LANES(N_LANES)) u_props
(
	.i_clock      (i_clock),
	.i_reset      (i_reset),
	.i_state      (state_q),
	.i_match      (i_match),
	.i_timer_done (i_timer_done),
	.i_match_mask (o_match_mask),
	.i_restart    (o_restart)
);

// File: test/am_lock_tb.sv
module am_lock_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int AM_PERIOD  = 16;
	localparam int AW         = am_lock_pkg::AM_LEN;
	localparam int LW         = am_lock_pkg::LANE_W;
	localparam int ROW_CYCLES = 20; // Write, payload, gaps, marker, check.
	localparam am_lock_pkg::lock_state_e IDLE = am_lock_pkg::ST_IDLE;
	localparam am_lock_pkg::lock_state_e FIND = am_lock_pkg::ST_FIND;
	localparam am_lock_pkg::lock_state_e CONF = am_lock_pkg::ST_CONFIRM;
	localparam am_lock_pkg::lock_state_e LOCK = am_lock_pkg::ST_LOCKED;

	typedef struct
	{
		string                    name;
		bit                       wr;
		bit                       addr;
		logic [7:0]               wdata;
		logic [LW-1:0]            lane;
		bit                       corrupt;
		logic                     exp_locked;
		logic [LW-1:0]            exp_lane;
		am_lock_pkg::lock_state_e exp_state;
	} row_t;

	logic          clock;
	logic          reset;
	logic          block_valid;
	logic [AW-1:0] am_value;
	logic          cfg_write;
	logic          cfg_addr;
	logic [7:0]    cfg_wdata;
	logic [7:0]    cfg_rdata;
	logic          locked;
	logic [LW-1:0] lane;

	row_t                    rows[$];
	int                      cycle_count = 0;
	int                      cycle_limit = 0;
	am_lock_pkg::am_cfg_t    exp_cfg;
	am_lock_pkg::am_status_t exp_status;

	am_lock_top #(.AM_PERIOD(AM_PERIOD)) UUT
	(
		.i_clock       (clock),
		.i_reset       (reset),
		.i_block_valid (block_valid),
		.i_am_value    (am_value),
		.i_cfg_write   (cfg_write),
		.i_cfg_addr    (cfg_addr),
		.i_cfg_wdata   (cfg_wdata),
		.o_cfg_rdata   (cfg_rdata),
		.o_locked      (locked),
		.o_lane        (lane)
	);

	always #5 clock = ~clock;

	task automatic stop_on_failure(input string reason);
		$display(">>> FAIL");
		$fatal(1, "%s", reason);
	endtask

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if ((cycle_limit > 0) && (cycle_count >= cycle_limit))
			stop_on_failure($sformatf("Timeout: run not finished after %0d cycles.", cycle_limit));
	end

	task automatic check_locked(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: o_locked expected %0b, actual %0b", name, expected, actual);
			stop_on_failure("o_locked mismatch.");
		end
	endtask

	task automatic check_lane(input string name, input logic [LW-1:0] expected,
		input logic [LW-1:0] actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: o_lane expected %0d, actual %0d", name, expected, actual);
			stop_on_failure("o_lane mismatch.");
		end
	endtask

	task automatic check_status(input string name, input am_lock_pkg::am_status_t expected,
		input am_lock_pkg::am_status_t actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: status expected locked %0b lane %0d state %0d, actual %0b %0d %0d",
				name, expected.locked, expected.lane, expected.state,
				actual.locked, actual.lane, actual.state);
			stop_on_failure("Status register mismatch.");
		end
	endtask

	task automatic check_cfg(input string name, input am_lock_pkg::am_cfg_t expected,
		input am_lock_pkg::am_cfg_t actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: control expected %h, actual %h", name, expected, actual);
			stop_on_failure("Control register mismatch.");
		end
	endtask

	function automatic bit is_marker(input logic [AW-1:0] value);
		for (int i = 0; i < am_lock_pkg::N_LANES; i++)
		begin
			if (am_lock_pkg::am_table(LW'(i)) == value)
				return 1'b1;
		end
		return 1'b0;
	endfunction

	function automatic logic [AW-1:0] random_payload();
		logic [63:0] raw;
		raw = {$urandom(), $urandom()};
		while (is_marker(raw[AW-1:0]))
			raw = {$urandom(), $urandom()}; // Payload must never look like a marker.
		return raw[AW-1:0];
	endfunction

	function automatic logic [AW-1:0] flip_bit(input logic [AW-1:0] marker);
		int pos;
		pos = int'($urandom_range(AW - 1, 0));
		return marker ^ (AW'(1) << pos);
	endfunction

	task automatic drive_cycle(input logic valid, input logic [AW-1:0] value,
		input logic write, input logic addr, input logic [7:0] wdata);
		@(posedge clock);
		#1;
		block_valid = valid;
		am_value    = value;
		cfg_write   = write;
		cfg_addr    = addr;
		cfg_wdata   = wdata;
	endtask

	task automatic add_row(input string name, input bit wr, input bit addr,
		input logic [7:0] wdata, input logic [LW-1:0] lane_sel, input bit corrupt,
		input logic exp_locked, input logic [LW-1:0] exp_lane,
		input am_lock_pkg::lock_state_e exp_state);
		row_t row;
		row.name       = name;
		row.wr         = wr;
		row.addr       = addr;
		row.wdata      = wdata;
		row.lane       = lane_sel;
		row.corrupt    = corrupt;
		row.exp_locked = exp_locked;
		row.exp_lane   = exp_lane;
		row.exp_state  = exp_state;
		rows.push_back(row);
	endtask

	task automatic play_row(input row_t row);
		logic [AW-1:0] marker;
		bit            disables;
		marker   = am_lock_pkg::am_table(row.lane);
		disables = row.wr && !row.addr && !row.wdata[0];
		if (row.wr)
		begin
			drive_cycle(1'b0, '0, 1'b1, row.addr, row.wdata);
			if (!row.addr)
			begin
				exp_cfg.enable      = row.wdata[0];
				exp_cfg.good_thresh = row.wdata[3:1];
				exp_cfg.bad_thresh  = row.wdata[6:4];
			end
		end
		for (int b = 0; b < AM_PERIOD - 1; b++)
		begin
			if ((b == 4) || (b == 9))
				drive_cycle(1'b0, marker, 1'b0, 1'b0, 8'h00); // Gap the timer must skip.
			drive_cycle(1'b1, random_payload(), 1'b0, 1'b0, 8'h00);
			if ((b == 1) && disables)
				check_locked({row.name, "_first_block"}, 1'b0, locked);
		end
		drive_cycle(1'b1, row.corrupt ? flip_bit(marker) : marker, 1'b0, 1'b0, 8'h00);
		drive_cycle(1'b0, '0, 1'b0, 1'b1, 8'h00);
		#1;
		exp_status = '{locked: row.exp_locked, lane: row.exp_lane, state: row.exp_state};
		check_locked(row.name, row.exp_locked, locked);
		check_lane(row.name, row.exp_lane, lane);
		check_status(row.name, exp_status, am_lock_pkg::am_status_t'(cfg_rdata));
		cfg_addr = 1'b0;
		#1;
		check_cfg(row.name, exp_cfg, am_lock_pkg::am_cfg_t'(cfg_rdata[6:0]));
	endtask

	initial
	begin
		void'($urandom(32'h0504_6362));
		clock       = 1'b0;
		reset       = 1'b1;
		block_valid = 1'b0;
		am_value    = '0;
		cfg_write   = 1'b0;
		cfg_addr    = 1'b0;
		cfg_wdata   = 8'h00;
		exp_cfg     = '{bad_thresh: 3'd4, good_thresh: 3'd2, enable: 1'b1};

		// Name, write, addr, data, lane, corrupt, locked, lane, state.
		add_row("acq_first",     0, 0, 8'h00,  7, 0, 0,  7, CONF);
		add_row("acq_second",    0, 0, 8'h00,  7, 0, 1,  7, LOCK);
		add_row("loss_miss1",    0, 0, 8'h00,  7, 1, 1,  7, LOCK);
		add_row("loss_miss2",    0, 0, 8'h00,  7, 1, 1,  7, LOCK);
		add_row("loss_miss3",    0, 0, 8'h00,  7, 1, 1,  7, LOCK);
		add_row("loss_miss4",    0, 0, 8'h00,  7, 1, 0,  0, FIND);
		add_row("relock_first",  0, 0, 8'h00, 12, 0, 0, 12, CONF);
		add_row("relock_second", 0, 0, 8'h00, 12, 0, 1, 12, LOCK);
		add_row("bad1_drop",     1, 0, 8'h15, 12, 1, 0,  0, FIND);
		add_row("confirm_find3", 0, 0, 8'h00,  3, 0, 0,  3, CONF);
		add_row("confirm_lane5", 0, 0, 8'h00,  5, 0, 0,  0, FIND);
		add_row("good3_first",   1, 0, 8'h17,  3, 0, 0,  3, CONF);
		add_row("good3_second",  0, 0, 8'h00,  3, 0, 0,  3, CONF);
		add_row("good3_third",   0, 0, 8'h00,  3, 0, 1,  3, LOCK);
		add_row("bad1_miss",     0, 0, 8'h00,  3, 1, 0,  0, FIND);
		add_row("lane9_first",   0, 0, 8'h00,  9, 0, 0,  9, CONF);
		add_row("lane9_second",  0, 0, 8'h00,  9, 0, 0,  9, CONF);
		add_row("lane9_third",   0, 0, 8'h00,  9, 0, 1,  9, LOCK);
		add_row("disable",       1, 0, 8'h16,  9, 0, 0,  0, IDLE);
		add_row("enable_again",  1, 0, 8'h17,  4, 0, 0,  4, CONF);
		add_row("status_write",  1, 1, 8'hFF,  4, 0, 0,  4, CONF);
		add_row("lane4_lock",    0, 0, 8'h00,  4, 0, 1,  4, LOCK);
		cycle_limit = rows.size() * ROW_CYCLES + 50;

		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;
		#1;
		check_cfg("reset_ctrl", exp_cfg, am_lock_pkg::am_cfg_t'(cfg_rdata[6:0]));
		check_locked("reset_locked", 1'b0, locked);
		check_lane("reset_lane", '0, lane);
		drive_cycle(1'b1, random_payload(), 1'b0, 1'b0, 8'h00); // IDLE to FIND.
		drive_cycle(1'b0, '0, 1'b0, 1'b1, 8'h00);
		#1;
		exp_status = '{locked: 1'b0, lane: '0, state: FIND};
		check_status("reset_status", exp_status, am_lock_pkg::am_status_t'(cfg_rdata));

		foreach (rows[i])
			play_row(rows[i]);

		$display(">>> PASS");
		$finish;
	end

endmodule
